//--- test/hv_core_vectors.txt
# op addr data flt exp (hex). op 0 idle data cycles, 1 write, 2 read expect exp, 3 faults flt
# for data cycles, 4 test mode, 5 random pwm, 6 random io read (exp=rtmon), 8 check, f end test
8 0 0 00 0000
2 4 0 00 0000
2 0 0 00 0000
2 1 0 00 0000
2 2 0 00 0000
2 3 0 00 0000
2 7 0 00 0000
f 0 1 00 0000
3 0 3 3f 0000
2 2 0 00 0000
3 0 4 01 0000
2 2 0 00 0001
3 0 4 3e 0000
2 2 0 00 003f
1 2 3f 00 0000
0 0 2 00 0000
2 2 0 00 0000
f 0 2 00 0000
1 1 1234 00 0000
8 0 0 00 0000
1 0 0002 00 0000
0 0 2 00 0000
1 1 1234 00 0000
8 0 0 00 1234
2 1 0 00 1234
2 4 0 00 0002
1 0 0003 00 0000
0 0 2 00 0000
8 0 1 00 1234
5 0 20 00 0000
2 4 0 00 0003
f 0 3 00 0000
1 0 000b 00 0000
3 0 4 01 0000
0 0 1 00 0000
8 0 2 00 1234
0 0 28 00 0000
2 4 0 00 0004
1 0 0000 00 0000
1 2 01 00 0000
0 0 2 00 0000
8 0 0 00 1234
2 4 0 00 0000
1 0 001b 00 0000
0 0 4 00 0000
8 0 1 00 1234
3 0 4 10 0000
0 0 1 00 0000
8 0 2 00 1234
0 0 30 00 0000
1 0 0000 00 0000
1 2 10 00 0000
0 0 2 00 0000
8 0 0 00 1234
2 4 0 00 0000
f 0 4 00 0000
4 0 1 00 0000
0 0 2 00 0000
8 0 4 00 1234
2 4 0 00 0001
4 0 0 00 0000
0 0 2 00 0000
8 0 0 00 1234
2 4 0 00 0000
f 0 5 00 0000
6 0 0 00 0000
6 0 0 00 0000
6 0 0 00 0000
1 0 0004 00 0000
6 0 0 00 0001
6 0 0 00 0001
6 0 0 00 0001
2 0 0 00 0004
f 0 6 00 0000

//--- sources.f
+incdir+design
design/hv_pkg.sv
design/hv_fault_if.sv
design/hv_fault_filter.sv
design/hv_reg_slv.sv
design/hv_ctrl_unit.sv
design/hv_pwm_intb_encode.sv
design/hv_core_top.sv
test/tb_clk_gen.sv
test/tb_checker.sv
test/tb_hv_core.sv

//--- run_sim.sh
#!/bin/sh
# build the hv core testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f sources.f --top-module tb_hv_core -o tb_hv_core
./obj_dir/tb_hv_core > sim.log 2>&1
cat sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "simulation ended without a verdict, see sim.log"
    exit 1
fi

//--- test/tb_hv_core.sv
//============================================================================
// hv core testbench
// reads the vector file, drives the dut a nanosecond after each rising edge
// and bounds the run with a cycle counter
//============================================================================
`timescale 1ns/1ps
`include "hv_defines.svh"

module tb_hv_core;

localparam int MAX_VEC = 128;

logic               i_clk, i_rst_n;
logic               i_reg_wen, i_reg_ren;
logic [2:0]         i_reg_addr;
logic [15:0]        i_reg_wdata;
logic               i_hv_vcc_uv, i_hv_vcc_ov, i_hv_ot, i_hv_oc;
logic               i_hv_desat_flt, i_hv_scp_flt;
logic               i_vge_vce, i_io_fsiso, i_io_pwm, i_io_fsstate;
logic               i_io_fsenb_n, i_io_intb, i_io_inta;
logic               i_io_test_mode, i_ang_dgt_pwm_wv;
logic [15:0]        o_reg_rdata;
logic               o_reg_rack;
logic               o_dgt_ang_pwm_en, o_dgt_ang_fsc_en, o_fsm_ang_test_en;
logic               o_pwmn_intb;
logic [15:0]        drv_cfg;

logic [15:0]        rd_exp, drv_exp;
logic               chk_req, end_req;
logic [2:0]         en_exp;
logic [7:0]         test_id;

logic [3:0]         v_op   [MAX_VEC];
logic [2:0]         v_addr [MAX_VEC];
logic [15:0]        v_data [MAX_VEC];
logic [5:0]         v_flt  [MAX_VEC];
logic [15:0]        v_exp  [MAX_VEC];
int                 n_vec   = 0;
int                 limit   = 0;
int                 cyc_cnt = 0;
int                 hs_err  = 0;
int                 err_cnt, test_cnt;
logic [31:0]        lcg_state = 32'hd8cb;

tb_clk_gen u_clk_gen (.o_clk(i_clk), .o_rst_n(i_rst_n));

hv_core_top i_hv_core_top (
    .i_reg_wen(i_reg_wen), .i_reg_ren(i_reg_ren), .i_reg_addr(i_reg_addr),
    .i_reg_wdata(i_reg_wdata), .o_reg_rdata(o_reg_rdata), .o_reg_rack(o_reg_rack),
    .i_hv_vcc_uv(i_hv_vcc_uv), .i_hv_vcc_ov(i_hv_vcc_ov), .i_hv_ot(i_hv_ot),
    .i_hv_oc(i_hv_oc), .i_hv_desat_flt(i_hv_desat_flt), .i_hv_scp_flt(i_hv_scp_flt),
    .i_vge_vce(i_vge_vce), .i_io_fsiso(i_io_fsiso), .i_io_pwm(i_io_pwm),
    .i_io_fsstate(i_io_fsstate), .i_io_fsenb_n(i_io_fsenb_n), .i_io_intb(i_io_intb),
    .i_io_inta(i_io_inta), .i_io_test_mode(i_io_test_mode),
    .i_ang_dgt_pwm_wv(i_ang_dgt_pwm_wv), .o_dgt_ang_pwm_en(o_dgt_ang_pwm_en),
    .o_dgt_ang_fsc_en(o_dgt_ang_fsc_en), .o_fsm_ang_test_en(o_fsm_ang_test_en),
    .o_pwmn_intb(o_pwmn_intb), .o_reg_drv_cfg(drv_cfg),
    .i_clk(i_clk), .i_rst_n(i_rst_n)
);

tb_checker u_checker (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_reg_wen(i_reg_wen), .i_reg_ren(i_reg_ren),
    .i_reg_addr(i_reg_addr), .i_reg_wdata(i_reg_wdata), .i_reg_rdata(o_reg_rdata),
    .i_reg_rack(o_reg_rack), .i_rd_exp(rd_exp), .i_pwm_wv(i_ang_dgt_pwm_wv),
    .i_pwm_en(o_dgt_ang_pwm_en), .i_fsc_en(o_dgt_ang_fsc_en),
    .i_test_en(o_fsm_ang_test_en), .i_pwmn_intb(o_pwmn_intb), .i_drv_cfg(drv_cfg),
    .i_chk_req(chk_req), .i_en_exp(en_exp), .i_drv_exp(drv_exp), .i_end_req(end_req),
    .i_test_id(test_id), .o_err_cnt(err_cnt), .o_test_cnt(test_cnt)
);

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

task automatic next_cycle();
    @(posedge i_clk);
    #1;
endtask

task automatic write_reg(input logic [2:0] addr, input logic [15:0] data);
    i_reg_wen   = 1'b1;
    i_reg_addr  = addr;
    i_reg_wdata = data;
    next_cycle();
    i_reg_wen   = 1'b0;
endtask

task automatic read_reg(input logic [2:0] addr, input logic [15:0] exp_word);
    int wait_cyc;
    i_reg_ren  = 1'b1;
    i_reg_addr = addr;
    rd_exp     = exp_word;
    next_cycle();
    i_reg_ren  = 1'b0;
    wait_cyc   = 0;
    while (!o_reg_rack && wait_cyc < 8) begin
        next_cycle();
        wait_cyc++;
    end
    if (!o_reg_rack) begin
        $display("read of address %0d got no acknowledge", addr);
        hs_err++;
    end
endtask

task automatic run_faults(input logic [5:0] flags, input int cycles);
    {i_hv_scp_flt, i_hv_desat_flt, i_hv_oc, i_hv_ot, i_hv_vcc_ov, i_hv_vcc_uv} = flags;
    repeat (cycles) next_cycle();
    {i_hv_scp_flt, i_hv_desat_flt, i_hv_oc, i_hv_ot, i_hv_vcc_ov, i_hv_vcc_uv} = '0;
endtask

task automatic drive_random_pwm(input int cycles);
    repeat (cycles) begin
        lcg_state        = lcg_next(lcg_state);
        i_ang_dgt_pwm_wv = lcg_state[16];
        next_cycle();
    end
    i_ang_dgt_pwm_wv = 1'b0;
endtask

task automatic read_random_io(input logic rtmon);
    logic [6:0]  lv;
    logic [15:0] exp_word;
    lcg_state = lcg_next(lcg_state);
    lv        = lcg_state[22:16];
    {i_vge_vce, i_io_fsiso, i_io_pwm, i_io_fsstate, i_io_fsenb_n, i_io_intb, i_io_inta} = lv;
    exp_word  = {8'h00, lv[6] ^ rtmon, 1'b0, lv[5:0]};  // monitor in bit 7
    read_reg(`ADDR_STATUS_IO, exp_word);
endtask

task automatic check_outputs(input logic [2:0] en, input logic [15:0] drv);
    chk_req = 1'b1;
    en_exp  = en;
    drv_exp = drv;
    next_cycle();
    chk_req = 1'b0;
endtask

task automatic end_test(input logic [7:0] id);
    end_req = 1'b1;
    test_id = id;
    next_cycle();
    end_req = 1'b0;
endtask

//============================================================================
// main sequence
//============================================================================
initial begin
    int             fd;
    int             code;
    string          line;
    logic [3:0]     op;
    logic [2:0]     addr;
    logic [15:0]    data;
    logic [5:0]     flt;
    logic [15:0]    exp_word;
    {i_reg_wen, i_reg_ren, i_reg_addr, i_reg_wdata} = '0;
    {i_hv_scp_flt, i_hv_desat_flt, i_hv_oc, i_hv_ot, i_hv_vcc_ov, i_hv_vcc_uv} = '0;
    {i_vge_vce, i_io_fsiso, i_io_pwm, i_io_fsstate, i_io_fsenb_n, i_io_intb, i_io_inta} = '0;
    i_io_test_mode   = 1'b0;
    i_ang_dgt_pwm_wv = 1'b0;
    {rd_exp, drv_exp, chk_req, end_req, en_exp, test_id} = '0;

    fd = $fopen("test/hv_core_vectors.txt", "r");
    if (fd == 0) begin
        $display("cannot open the vector file");
        hs_err++;
    end else begin
        while (!$feof(fd) && n_vec < MAX_VEC) begin
            line = "";
            code = $fgets(line, fd);
            if (code != 0)
                code = $sscanf(line, "%h %h %h %h %h", op, addr, data, flt, exp_word);
            if (code == 5) begin
                v_op[n_vec]   = op;
                v_addr[n_vec] = addr;
                v_data[n_vec] = data;
                v_flt[n_vec]  = flt;
                v_exp[n_vec]  = exp_word;
                n_vec++;
            end
        end
        $fclose(fd);
    end
    limit = n_vec * 40 + 200;

    @(posedge i_rst_n);
    next_cycle();
    for (int i = 0; i < n_vec; i++) begin
        case (v_op[i])
            4'h0: repeat (int'(v_data[i])) next_cycle();
            4'h1: write_reg(v_addr[i], v_data[i]);
            4'h2: read_reg(v_addr[i], v_exp[i]);
            4'h3: run_faults(v_flt[i], int'(v_data[i]));
            4'h4: begin
                i_io_test_mode = v_data[i][0];
                next_cycle();
            end
            4'h5: drive_random_pwm(int'(v_data[i]));
            4'h6: read_random_io(v_exp[i][0]);
            4'h8: check_outputs(v_data[i][2:0], v_exp[i]);
            4'hf: end_test(v_data[i][7:0]);
            default: begin
                $display("unknown vector operation %h in vector %0d", v_op[i], i);
                hs_err++;
            end
        endcase
    end

    $display("%0d tests run, %0d errors", test_cnt, err_cnt + hs_err);
    if (err_cnt == 0 && hs_err == 0 && test_cnt > 0) begin
        $display("test passed");
    end else begin
        $display("test failed");
    end
    $finish;
end

// run limit from the vector count
initial begin
    wait (limit > 0);
    while (cyc_cnt < limit) begin
        @(posedge i_clk);
        cyc_cnt++;
    end
    $display("timeout, the vectors did not finish within %0d cycles", limit);
    $display("test failed");
    $finish;
end

endmodule

//--- test/tb_checker.sv
//============================================================================
// hv core checker
// watches the dut ports, predicts read acks, enables and the pwmn/intb line,
// counts errors and finished tests
//============================================================================
`timescale 1ns/1ps

module tb_checker (
    input  logic        i_clk           ,
    input  logic        i_rst_n         ,
    input  logic        i_reg_wen       ,
    input  logic        i_reg_ren       ,
    input  logic [2:0]  i_reg_addr      ,
    input  logic [15:0] i_reg_wdata     ,
    input  logic [15:0] i_reg_rdata     ,
    input  logic        i_reg_rack      ,
    input  logic [15:0] i_rd_exp        ,
    input  logic        i_pwm_wv        ,
    input  logic        i_pwm_en        ,
    input  logic        i_fsc_en        ,
    input  logic        i_test_en       ,
    input  logic        i_pwmn_intb     ,
    input  logic [15:0] i_drv_cfg       ,
    input  logic        i_chk_req       ,
    input  logic [2:0]  i_en_exp        , // {test, fsc, pwm}
    input  logic [15:0] i_drv_exp       ,
    input  logic        i_end_req       ,
    input  logic [7:0]  i_test_id       ,
    output int          o_err_cnt       ,
    output int          o_test_cnt
);

int             err_cnt     = 0;
int             test_cnt    = 0;
int             test_err    = 0;
int             pulse_exp   = 0;
int             low_cnt     = 0;
logic           rack_due    = 1'b0;
logic [15:0]    rdata_due   = '0;
logic           pwm_d1      = 1'b0;
logic           pwm_en_d1   = 1'b0;
logic           fsc_d1      = 1'b0;
logic           pulse_on    = 1'b0;
logic [3:0]     intb_w      = '0;

task automatic report_err(input string sig, input logic [15:0] exp_val,
                          input logic [15:0] got_val);
    $display("ERROR %s expected %h got %h at %0t ns", sig, exp_val, got_val, $time);
    test_err++;
    err_cnt++;
endtask

task automatic report_fail(input string msg);
    $display("%s at %0t ns", msg, $time);
    test_err++;
    err_cnt++;
endtask

//============================================================================
// sampled at the falling edge between drive points
//============================================================================
always @(negedge i_clk) begin
    if (!i_rst_n) begin
        rack_due  = 1'b0;
        pulse_on  = 1'b0;
        pwm_en_d1 = 1'b0;
        fsc_d1    = 1'b0;
        intb_w    = '0;
    end else begin
        // ack exactly one cycle after each read strobe
        if (i_reg_rack !== rack_due)
            report_err("o_reg_rack", 16'(rack_due), 16'(i_reg_rack));
        else if (rack_due && i_reg_rdata !== rdata_due)
            report_err("o_reg_rdata", rdata_due, i_reg_rdata);
        rack_due  = i_reg_ren;
        rdata_due = i_rd_exp;

        if (int'(i_pwm_en) + int'(i_fsc_en) + int'(i_test_en) > 1)
            report_fail("more than one analog enable is high");

        if (i_fsc_en && !fsc_d1) begin
            pulse_on  = 1'b1;               // low pulse starts next cycle
            pulse_exp = (int'(intb_w) + 1) * 8;
            low_cnt   = 0;
        end else if (pulse_on) begin
            if (!i_pwmn_intb) begin
                low_cnt++;
            end else if (low_cnt != 0) begin
                pulse_on = 1'b0;
                if (low_cnt != pulse_exp)
                    report_err("o_pwmn_intb low cycles", 16'(pulse_exp), 16'(low_cnt));
            end
            if (pulse_on && !i_fsc_en) begin
                report_fail("fault state left before the intb pulse ended");
                pulse_on = 1'b0;
            end
        end else if (pwm_en_d1) begin
            if (i_pwmn_intb !== ~pwm_d1)
                report_err("o_pwmn_intb", 16'(!pwm_d1), 16'(i_pwmn_intb));
        end else if (i_pwmn_intb !== 1'b1) begin
            report_err("o_pwmn_intb", 16'h1, 16'(i_pwmn_intb));
        end

        if (i_reg_wen && i_reg_addr == 3'd0)
            intb_w = i_reg_wdata[6:3];      // mode register width field

        if (i_chk_req) begin
            if (i_pwm_en !== i_en_exp[0])
                report_err("o_dgt_ang_pwm_en", 16'(i_en_exp[0]), 16'(i_pwm_en));
            if (i_fsc_en !== i_en_exp[1])
                report_err("o_dgt_ang_fsc_en", 16'(i_en_exp[1]), 16'(i_fsc_en));
            if (i_test_en !== i_en_exp[2])
                report_err("o_fsm_ang_test_en", 16'(i_en_exp[2]), 16'(i_test_en));
            if (i_drv_cfg !== i_drv_exp)
                report_err("o_reg_drv_cfg", i_drv_exp, i_drv_cfg);
        end

        if (i_end_req) begin
            test_cnt++;
            $display("test %0d finished, %0d errors", i_test_id, test_err);
            test_err = 0;
        end

        pwm_d1    = i_pwm_wv;
        pwm_en_d1 = i_pwm_en;
        fsc_d1    = i_fsc_en;
    end
end

assign o_err_cnt  = err_cnt;
assign o_test_cnt = test_cnt;

endmodule

//--- test/tb_clk_gen.sv
//============================================================================
// testbench clock and reset
// 4 ns clock, reset held low for the first 10 cycles
//============================================================================
`timescale 1ns/1ps

module tb_clk_gen (
    output logic    o_clk       ,
    output logic    o_rst_n
);

initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
end

initial begin
    o_rst_n = 1'b0;
    repeat (10) @(posedge o_clk);
    #1 o_rst_n = 1'b1;
end

endmodule

//--- design/hv_core_top.sv
//============================================================================
// hv core top
// high-voltage side control core: fault filter, register slave, control
// state machine and pwmn/intb encoder
//============================================================================
`timescale 1ns/1ps
`include "hv_defines.svh"

module hv_core_top (
    input  logic                    i_reg_wen           ,
    input  logic                    i_reg_ren           ,
    input  logic [`REG_AW-1:0]      i_reg_addr          ,
    input  logic [`REG_DW-1:0]      i_reg_wdata         ,
    output logic [`REG_DW-1:0]      o_reg_rdata         ,
    output logic                    o_reg_rack          ,

    input  logic                    i_hv_vcc_uv         ,
    input  logic                    i_hv_vcc_ov         ,
    input  logic                    i_hv_ot             ,
    input  logic                    i_hv_oc             ,
    input  logic                    i_hv_desat_flt      ,
    input  logic                    i_hv_scp_flt        ,

    input  logic                    i_vge_vce           ,
    input  logic                    i_io_fsiso          ,
    input  logic                    i_io_pwm            ,
    input  logic                    i_io_fsstate        ,
    input  logic                    i_io_fsenb_n        ,
    input  logic                    i_io_intb           ,
    input  logic                    i_io_inta           ,

    input  logic                    i_io_test_mode      ,
    input  logic                    i_ang_dgt_pwm_wv    , // analog pwm wave

    output logic                    o_dgt_ang_pwm_en    ,
    output logic                    o_dgt_ang_fsc_en    ,
    output logic                    o_fsm_ang_test_en   ,
    output logic                    o_pwmn_intb         ,
    output hv_pkg::reg_drv_cfg_t    o_reg_drv_cfg       ,

    input  logic                    i_clk               ,
    input  logic                    i_rst_n
);

hv_pkg::reg_mode_t      reg_mode        ;
hv_pkg::ctrl_st_e       ctrl_state      ;
logic                   cfg_wr_en       ;

hv_fault_if u_fault_if ();

hv_fault_filter u_hv_fault_filter (
    .i_hv_vcc_uv        (i_hv_vcc_uv        ),
    .i_hv_vcc_ov        (i_hv_vcc_ov        ),
    .i_hv_ot            (i_hv_ot            ),
    .i_hv_oc            (i_hv_oc            ),
    .i_hv_desat_flt     (i_hv_desat_flt     ),
    .i_hv_scp_flt       (i_hv_scp_flt       ),
    .flt                (u_fault_if.filt    ),
    .i_clk              (i_clk              ),
    .i_rst_n            (i_rst_n            )
);

hv_reg_slv u_hv_reg_slv (
    .i_reg_wen          (i_reg_wen          ),
    .i_reg_ren          (i_reg_ren          ),
    .i_reg_addr         (i_reg_addr         ),
    .i_reg_wdata        (i_reg_wdata        ),
    .o_reg_rdata        (o_reg_rdata        ),
    .o_reg_rack         (o_reg_rack         ),
    .i_cfg_wr_en        (cfg_wr_en          ),
    .i_state            (ctrl_state         ),
    .i_vge_vce          (i_vge_vce          ),
    .i_io_fsiso         (i_io_fsiso         ),
    .i_io_pwm           (i_io_pwm           ),
    .i_io_fsstate       (i_io_fsstate       ),
    .i_io_fsenb_n       (i_io_fsenb_n       ),
    .i_io_intb          (i_io_intb          ),
    .i_io_inta          (i_io_inta          ),
    .o_reg_mode         (reg_mode           ),
    .o_reg_drv_cfg      (o_reg_drv_cfg      ),
    .flt                (u_fault_if.regs    ),
    .i_clk              (i_clk              ),
    .i_rst_n            (i_rst_n            )
);

hv_ctrl_unit u_hv_ctrl_unit (
    .i_io_test_mode     (i_io_test_mode     ),
    .i_reg_mode         (reg_mode           ),
    .flt                (u_fault_if.ctrl    ),
    .o_state            (ctrl_state         ),
    .o_cfg_wr_en        (cfg_wr_en          ),
    .o_pwm_en           (o_dgt_ang_pwm_en   ),
    .o_fsc_en           (o_dgt_ang_fsc_en   ),
    .o_test_en          (o_fsm_ang_test_en  ),
    .i_clk              (i_clk              ),
    .i_rst_n            (i_rst_n            )
);

hv_pwm_intb_encode u_hv_pwm_intb_encode (
    .i_state            (ctrl_state             ),
    .i_intb_width       (reg_mode.intb_width    ),
    .i_pwm_wv           (i_ang_dgt_pwm_wv       ),
    .o_pwmn_intb        (o_pwmn_intb            ),
    .i_clk              (i_clk                  ),
    .i_rst_n            (i_rst_n                )
);

endmodule

//--- design/hv_pwm_intb_encode.sv
//============================================================================
// hv pwmn/intb encoder
// inverted pwm wave in normal state; a low pulse of (width+1) units on
// entry into fault
//============================================================================
`timescale 1ns/1ps
`include "hv_defines.svh"

module hv_pwm_intb_encode (
    input  hv_pkg::ctrl_st_e    i_state         ,
    input  logic [3:0]          i_intb_width    ,
    input  logic                i_pwm_wv        ,
    output logic                o_pwmn_intb     ,

    input  logic                i_clk           ,
    input  logic                i_rst_n
);

localparam int CNT_W = $clog2(16 * `INTB_UNIT_CYC) + 1;

hv_pkg::ctrl_st_e   state_d1        ;
logic               fault_entry     ;
logic [CNT_W-1:0]   pulse_len       ;
logic [CNT_W-1:0]   pulse_cnt       ;
logic               idle_lvl        ;
logic               pwmn_q          ;

assign fault_entry = (i_state == hv_pkg::ST_FAULT) && (state_d1 != hv_pkg::ST_FAULT);

// cycles left after the entry cycle
assign pulse_len = (CNT_W'(i_intb_width) + 1'b1) * CNT_W'(`INTB_UNIT_CYC) - 1'b1;

assign idle_lvl  = (i_state == hv_pkg::ST_NORMAL) ? ~i_pwm_wv : 1'b1;

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        state_d1  <= hv_pkg::ST_WAIT;
        pulse_cnt <= '0;
        pwmn_q    <= 1'b1;
    end else begin
        state_d1 <= i_state;
        if (fault_entry) begin
            pulse_cnt <= pulse_len;
            pwmn_q    <= 1'b0;
        end else if (pulse_cnt != '0) begin
            pulse_cnt <= pulse_cnt - 1'b1;   // hold low
            pwmn_q    <= 1'b0;
        end else begin
            pwmn_q    <= idle_lvl;
        end
    end
end

assign o_pwmn_intb = pwmn_q;

endmodule

//--- design/hv_ctrl_unit.sv
//============================================================================
// hv control unit
// main state machine: wait, test, cfg, normal and fault, with registered
// analog enables
//============================================================================
`timescale 1ns/1ps

module hv_ctrl_unit (
    input  logic                    i_io_test_mode  ,
    input  hv_pkg::reg_mode_t       i_reg_mode      ,

    hv_fault_if.ctrl                flt             ,

    output hv_pkg::ctrl_st_e        o_state         ,
    output logic                    o_cfg_wr_en     ,
    output logic                    o_pwm_en        ,
    output logic                    o_fsc_en        ,
    output logic                    o_test_en       ,

    input  logic                    i_clk           ,
    input  logic                    i_rst_n
);

hv_pkg::ctrl_st_e   cur_st      ;
hv_pkg::ctrl_st_e   nxt_st      ;
logic               flt_any     ;

assign flt_any = (flt.err != '0);

//============================================================================
// next state
//============================================================================
always_comb begin
    nxt_st = cur_st;
    case (cur_st)
        hv_pkg::ST_WAIT: begin
            if (i_io_test_mode)
                nxt_st = hv_pkg::ST_TEST;
            else if (i_reg_mode.cfg_en)
                nxt_st = hv_pkg::ST_CFG;
        end
        hv_pkg::ST_TEST: begin
            if (!i_io_test_mode)
                nxt_st = hv_pkg::ST_WAIT;
        end
        hv_pkg::ST_CFG: begin
            if (flt_any)
                nxt_st = hv_pkg::ST_FAULT;
            else if (i_reg_mode.normal_en)
                nxt_st = hv_pkg::ST_NORMAL;
        end
        hv_pkg::ST_NORMAL: begin
            if (flt_any)
                nxt_st = hv_pkg::ST_FAULT;
        end
        hv_pkg::ST_FAULT: begin
            if (!flt_any)
                nxt_st = hv_pkg::ST_WAIT;   // all faults cleared
        end
        default: nxt_st = hv_pkg::ST_WAIT;
    endcase
end

// enables decoded from next state so they line up with cur_st
always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        cur_st      <= hv_pkg::ST_WAIT;
        o_cfg_wr_en <= 1'b0;
        o_pwm_en    <= 1'b0;
        o_fsc_en    <= 1'b0;
        o_test_en   <= 1'b0;
    end else begin
        cur_st      <= nxt_st;
        o_cfg_wr_en <= (nxt_st == hv_pkg::ST_CFG);
        o_pwm_en    <= (nxt_st == hv_pkg::ST_NORMAL);
        o_fsc_en    <= (nxt_st == hv_pkg::ST_FAULT);
        o_test_en   <= (nxt_st == hv_pkg::ST_TEST);
    end
end

assign o_state = cur_st;

endmodule

//--- design/hv_reg_slv.sv
//============================================================================
// hv register slave
// strobe port register file: mode and drive config registers, fault clear
// strobes, and the fault/io/state status words
//============================================================================
`timescale 1ns/1ps
`include "hv_defines.svh"

module hv_reg_slv (
    input  logic                        i_reg_wen       ,
    input  logic                        i_reg_ren       ,
    input  logic [`REG_AW-1:0]          i_reg_addr      ,
    input  hv_pkg::reg_word_u           i_reg_wdata     ,
    output logic [`REG_DW-1:0]          o_reg_rdata     ,
    output logic                        o_reg_rack      ,

    input  logic                        i_cfg_wr_en     , // only in cfg state
    input  hv_pkg::ctrl_st_e            i_state         ,

    input  logic                        i_vge_vce       ,
    input  logic                        i_io_fsiso      ,
    input  logic                        i_io_pwm        ,
    input  logic                        i_io_fsstate    ,
    input  logic                        i_io_fsenb_n    ,
    input  logic                        i_io_intb       ,
    input  logic                        i_io_inta       ,

    output hv_pkg::reg_mode_t           o_reg_mode      ,
    output hv_pkg::reg_drv_cfg_t        o_reg_drv_cfg   ,

    hv_fault_if.regs                    flt             ,

    input  logic                        i_clk           ,
    input  logic                        i_rst_n
);

hv_pkg::reg_mode_t      mode_q          ;
hv_pkg::reg_drv_cfg_t   drv_cfg_q       ;
logic [`FLT_NUM-1:0]    clr_q           ;
logic                   rack_q          ;
logic [`REG_DW-1:0]     rdata_q         ;
logic [`REG_DW-1:0]     rd_word         ;
logic                   vmon            ;

//============================================================================
// write decode
//============================================================================
always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        mode_q    <= '0;
        drv_cfg_q <= '0;
        clr_q     <= '0;
    end else begin
        clr_q <= '0;
        if (i_reg_wen) begin
            case (i_reg_addr)
                `ADDR_MODE:       mode_q <= i_reg_wdata.mode;
                `ADDR_DRV_CFG: begin
                    if (i_cfg_wr_en)
                        drv_cfg_q <= i_reg_wdata.drv_cfg;
                end
                `ADDR_STATUS_FLT: clr_q  <= i_reg_wdata.raw[`FLT_NUM-1:0]; // w1c
                default: ;
            endcase
        end
    end
end

assign flt.clr = hv_pkg::flt_vec_t'(clr_q);

//============================================================================
// read path
//============================================================================
assign vmon = mode_q.rtmon ? ~i_vge_vce : i_vge_vce;

always_comb begin
    case (i_reg_addr)
        `ADDR_MODE:       rd_word = mode_q;
        `ADDR_DRV_CFG:    rd_word = drv_cfg_q;
        `ADDR_STATUS_FLT: rd_word = {{(`REG_DW-`FLT_NUM){1'b0}}, flt.err};
        `ADDR_STATUS_IO:  rd_word = {8'b0, vmon, 1'b0, i_io_fsiso, i_io_pwm,
                                     i_io_fsstate, i_io_fsenb_n, i_io_intb, i_io_inta};
        `ADDR_STATE:      rd_word = {{(`REG_DW-3){1'b0}}, i_state};
        default:          rd_word = '0;   // unmapped
    endcase
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n)
        rack_q <= 1'b0;
    else
        rack_q <= i_reg_ren;
end

always_ff @(posedge i_clk) begin
    if (i_reg_ren)
        rdata_q <= rd_word;
end

assign o_reg_rdata   = rdata_q;
assign o_reg_rack    = rack_q;
assign o_reg_mode    = mode_q;
assign o_reg_drv_cfg = drv_cfg_q;

endmodule

//--- design/hv_fault_filter.sv
//============================================================================
// hv fault filter
// glitch filter on the six analog fault flags; a flag that stays high for
// FLT_FILT_CYC cycles latches until its clear strobe
//============================================================================
`timescale 1ns/1ps
`include "hv_defines.svh"

module hv_fault_filter (
    input  logic        i_hv_vcc_uv     ,
    input  logic        i_hv_vcc_ov     ,
    input  logic        i_hv_ot         ,
    input  logic        i_hv_oc         ,
    input  logic        i_hv_desat_flt  ,
    input  logic        i_hv_scp_flt    ,

    hv_fault_if.filt    flt             ,

    input  logic        i_clk           ,
    input  logic        i_rst_n
);

localparam int CNT_W = $clog2(`FLT_FILT_CYC + 1);

logic [`FLT_NUM-1:0]    flag_raw                ;
logic [`FLT_NUM-1:0]    clr_vec                 ;
logic [`FLT_NUM-1:0]    err_q                   ;
logic [CNT_W-1:0]       run_cnt [`FLT_NUM]      ;

// same bit order as flt_vec_t
assign flag_raw = {i_hv_scp_flt, i_hv_desat_flt, i_hv_oc,
                   i_hv_ot, i_hv_vcc_ov, i_hv_vcc_uv};

assign clr_vec  = flt.clr;

//============================================================================
// run counters and sticky latches
//============================================================================
always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        err_q <= '0;
        for (int i = 0; i < `FLT_NUM; i++) begin
            run_cnt[i] <= '0;
        end
    end else begin
        for (int i = 0; i < `FLT_NUM; i++) begin
            if (clr_vec[i]) begin
                // new full run needed after a clear
                run_cnt[i] <= '0;
                err_q[i]   <= 1'b0;
            end else if (!flag_raw[i]) begin
                run_cnt[i] <= '0;
            end else begin
                if (run_cnt[i] != CNT_W'(`FLT_FILT_CYC))
                    run_cnt[i] <= run_cnt[i] + 1'b1;   // saturate
                if (run_cnt[i] == CNT_W'(`FLT_FILT_CYC - 1))
                    err_q[i] <= 1'b1;
            end
        end
    end
end

assign flt.err = hv_pkg::flt_vec_t'(err_q);

endmodule

//--- design/hv_fault_if.sv
//============================================================================
// hv fault interface
// latched fault flags and their per-flag clear strobes
//============================================================================
`timescale 1ns/1ps

interface hv_fault_if;

    hv_pkg::flt_vec_t err;      // latched faults
    hv_pkg::flt_vec_t clr;      // one-cycle clear per flag

    modport filt (output err, input  clr);
    modport regs (input  err, output clr);
    modport ctrl (input  err);

endinterface

//--- design/hv_pkg.sv
//============================================================================
// hv core package
// control states, register layouts and the decoded register write word
//============================================================================
`include "hv_defines.svh"

package hv_pkg;

    typedef enum logic [2:0] {
        ST_WAIT   = 3'd0,
        ST_TEST   = 3'd1,
        ST_CFG    = 3'd2,
        ST_NORMAL = 3'd3,
        ST_FAULT  = 3'd4
    } ctrl_st_e;

    typedef struct packed {
        logic [8:0] reserved;
        logic [3:0] intb_width;     // fault pulse = (w+1) units
        logic       rtmon;          // invert vge/vce monitor
        logic       cfg_en;
        logic       normal_en;
    } reg_mode_t;

    typedef struct packed {
        logic [3:0] oc_sel;
        logic [3:0] desat_sel;
        logic [3:0] snk_sel;
        logic [3:0] src_sel;
    } reg_drv_cfg_t;

    // one write word, decoded by address
    typedef union packed {
        logic [`REG_DW-1:0] raw;
        reg_mode_t          mode;
        reg_drv_cfg_t       drv_cfg;
    } reg_word_u;

    // uvlo in bit 0 up to scp in bit 5
    typedef struct packed {
        logic scp;
        logic desat;
        logic oc;
        logic ot;
        logic ovlo;
        logic uvlo;
    } flt_vec_t;

endpackage

//--- design/hv_defines.svh
//============================================================================
// hv core defines
// register map, bus widths and the cycle counts of the fault filter and the
// intb pulse encoder
//============================================================================
`ifndef HV_DEFINES_SVH
`define HV_DEFINES_SVH

// register port
`define REG_AW              3
`define REG_DW              16

// fault processing
`define FLT_NUM             6
`define FLT_FILT_CYC        4       // consecutive high cycles to latch

// pwmn/intb encoder
`define INTB_UNIT_CYC       8       // cycles per intb_width step

// register addresses
`define ADDR_MODE           3'd0
`define ADDR_DRV_CFG        3'd1
`define ADDR_STATUS_FLT     3'd2
`define ADDR_STATUS_IO      3'd3
`define ADDR_STATE          3'd4

`endif
